//--- hdl/lsu_pkg.sv
// ==========================================================================
// Shared definitions for the load/store unit address path
// Operand, address and register number types
// Memory opcode enumeration with access size and address form types
// Program counter register number and small classification helpers
// ==========================================================================

package lsu_pkg;

	// ==========================================================================
	// Operand and register types
	// ==========================================================================

	// A 64-bit operand value or generated address
	typedef logic [63:0] value_t;
	// The program counter is the same width as any other address
	typedef logic [63:0] pc_address_t;
	// Architectural register number
	typedef logic [6:0] aregno_t;
	// Left-shift amount applied to the index in the indexed form
	typedef logic [2:0] scale_t;
	// Load/store queue entry, carried along untouched
	typedef logic [3:0] tag_t;
	// One bit per byte lane of the 64-bit word, bit n is byte n
	typedef logic [7:0] byte_en_t;

	// A source register with this number reads as the program counter
	localparam aregno_t PC_REGNO = 7'd53;

	// ==========================================================================
	// Opcodes and access classification
	// ==========================================================================

	// Loads with a U suffix zero-extend, the others sign-extend.
	// LDX, STX and AMO always move a full octa
	typedef enum logic [6:0] {
		OP_NOP  = 7'h00,
		OP_LDB  = 7'h40,
		OP_LDBU = 7'h41,
		OP_LDW  = 7'h42,
		OP_LDWU = 7'h43,
		OP_LDT  = 7'h44,
		OP_LDTU = 7'h45,
		OP_LDO  = 7'h46,
		OP_LDX  = 7'h47,
		OP_STB  = 7'h48,
		OP_STW  = 7'h49,
		OP_STT  = 7'h4a,
		OP_STO  = 7'h4b,
		OP_STX  = 7'h4c,
		OP_AMO  = 7'h4f
	} opcode_e;

	// Access size, the width in bytes is 1 << size
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} mem_size_e;

	// How the effective address is formed, encoding 3 is unused
	typedef enum logic [1:0] {
		KIND_DISP    = 2'd0,
		KIND_INDEXED = 2'd1,
		KIND_ATOMIC  = 2'd2
	} mem_kind_e;

	// True for every opcode that the address path accepts
	function automatic logic is_mem_op(opcode_e op);
		return op inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO, OP_STX, OP_AMO};
	endfunction

	// Width of an access in bytes
	function automatic logic [3:0] size_bytes(mem_size_e sz);
		return 4'd1 << sz;
	endfunction

endpackage

//--- hdl/mem_op_if.sv
// ==========================================================================
// Decoded memory operation link from decode to address generation
// Carries the operands and the access classification of one operation
// ==========================================================================

`timescale 1ns/1ps

interface mem_op_if import lsu_pkg::*; ();

	// Strobe, the other fields only matter while this is high
	logic      valid;
	tag_t      tag;
	logic      is_store;
	logic      sign_ext;
	mem_size_e size;
	mem_kind_e kind;
	// Base operand after program counter substitution
	value_t    base;
	// Index operand, unscaled
	value_t    index;
	scale_t    scale;
	value_t    disp;

	// Decode side
	modport src (
		output valid, tag, is_store, sign_ext, size, kind,
		output base, index, scale, disp
	);

	// Address generation side
	modport dst (
		input valid, tag, is_store, sign_ext, size, kind,
		input base, index, scale, disp
	);

endinterface

//--- hdl/mem_addr_if.sv
// ==========================================================================
// Generated address link from address generation to alignment
// Carries the effective address and the access attributes
// ==========================================================================

`timescale 1ns/1ps

interface mem_addr_if import lsu_pkg::*; ();

	// Strobe, the other fields only matter while this is high
	logic      valid;
	tag_t      tag;
	logic      is_store;
	logic      sign_ext;
	mem_size_e size;
	// Full 64-bit effective address
	value_t    addr;

	// Address generation side
	modport src (
		output valid, tag, is_store, sign_ext, size, addr
	);

	// Alignment side
	modport dst (
		input valid, tag, is_store, sign_ext, size, addr
	);

endinterface

//--- hdl/lsu_decode.sv
// ==========================================================================
// First stage of the address path
// Classifies the opcode, substitutes the program counter for register
// operands that name it, and registers the decoded operation
// ==========================================================================

`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  tag_t        in_tag,
	input  opcode_e     opcode,
	input  scale_t      scale,
	input  aregno_t     ra,
	input  aregno_t     rb,
	input  value_t      a,
	input  value_t      b,
	input  value_t      imm,
	input  pc_address_t pc,
	mem_op_if.src       op
);

	logic      dec_store;
	logic      dec_sext;
	mem_size_e dec_size;
	mem_kind_e dec_kind;
	value_t    base_sel;
	value_t    index_sel;

	// Opcode classification into size, direction, extension and address form
	always_comb
	begin
		case (opcode)
			OP_LDB, OP_LDBU, OP_STB: dec_size = SZ_BYTE;
			OP_LDW, OP_LDWU, OP_STW: dec_size = SZ_WYDE;
			OP_LDT, OP_LDTU, OP_STT: dec_size = SZ_TETRA;
			// Octa loads and stores, indexed and atomic forms all move eight bytes
			default: dec_size = SZ_OCTA;
		endcase
		case (opcode)
			OP_LDX, OP_STX: dec_kind = KIND_INDEXED;
			// An atomic read-modify-write is treated as an octa access
			OP_AMO: dec_kind = KIND_ATOMIC;
			default: dec_kind = KIND_DISP;
		endcase
		// Only the loads without a U suffix sign-extend
		dec_sext  = opcode inside {OP_LDB, OP_LDW, OP_LDT};
		dec_store = opcode inside {OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
	end

	// Register 53 reads as the program counter
	assign base_sel = (ra == PC_REGNO) ? pc : a;

	// Atomics always take the plain b operand as their index
	assign index_sel = (opcode != OP_AMO && rb == PC_REGNO) ? pc : b;

	// ==========================================================================
	// Stage register
	// ==========================================================================

	// Non-memory opcodes are dropped here and never leave the stage
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			op.valid <= 1'b0;
		else
			op.valid <= in_valid && is_mem_op(opcode);
	end

	// Payload is loaded every cycle and only qualified by valid
	always_ff @(posedge clk)
	begin
		op.tag      <= in_tag;
		op.is_store <= dec_store;
		op.sign_ext <= dec_sext;
		op.size     <= dec_size;
		op.kind     <= dec_kind;
		op.base     <= base_sel;
		op.index    <= index_sel;
		op.scale    <= scale;
		op.disp     <= imm;
	end

	// A decoded store never sign-extends, and only the displacement form
	// carries a size below an octa
	a_class_consistent: assert property (
		@(posedge clk) disable iff (!rst_n)
		op.valid |-> !(op.is_store && op.sign_ext) &&
			(op.kind == KIND_DISP || op.size == SZ_OCTA)
	);

endmodule

//--- hdl/lsu_agen.sv
// ==========================================================================
// Second stage of the address path
// Forms the effective address for the displacement, indexed and atomic
// address forms and registers it with the access attributes
// ==========================================================================

`timescale 1ns/1ps

module lsu_agen import lsu_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	mem_op_if.dst  op,
	mem_addr_if.src ad
);

	value_t scaled_index;
	value_t addr_next;

	// The index is scaled even when it is the program counter
	assign scaled_index = op.index << op.scale;

	// Effective address for each form
	always_comb
	begin
		case (op.kind)
			KIND_INDEXED:
				addr_next = op.base + scaled_index + op.disp;
			// Atomics ignore the scale and the displacement
			KIND_ATOMIC:
				addr_next = op.base + op.index;
			default:
				addr_next = op.base + op.disp;
		endcase
	end

	// ==========================================================================
	// Stage register
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ad.valid <= 1'b0;
		else
			ad.valid <= op.valid;
	end

	// Attributes pass straight through alongside the new address
	always_ff @(posedge clk)
	begin
		ad.tag      <= op.tag;
		ad.is_store <= op.is_store;
		ad.sign_ext <= op.sign_ext;
		ad.size     <= op.size;
		ad.addr     <= addr_next;
	end

	// Decode only ever produces the three defined address forms
	a_kind_defined: assert property (
		@(posedge clk) disable iff (!rst_n)
		op.valid |-> op.kind inside {KIND_DISP, KIND_INDEXED, KIND_ATOMIC}
	);

endmodule

//--- hdl/lsu_align.sv
// ==========================================================================
// Third stage of the address path
// Derives the byte lane enables and the misalignment flag for the
// addressed 64-bit word and drives the unit's outputs
// ==========================================================================

`timescale 1ns/1ps

module lsu_align import lsu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	mem_addr_if.dst   ad,
	output logic      out_valid,
	output tag_t      out_tag,
	output logic      out_store,
	output logic      out_sign_ext,
	output mem_size_e out_size,
	output value_t    out_addr,
	output byte_en_t  out_byte_en,
	output logic      out_misaligned
);

	logic [3:0] width;
	logic [2:0] lane;
	byte_en_t   lane_mask;
	logic       misaligned;
	byte_en_t   byte_en_next;

	// Access width in bytes and the starting lane within the word
	assign width = size_bytes(ad.size);
	assign lane  = ad.addr[2:0];

	// Contiguous run of enables for each width, starting at lane 0
	always_comb
	begin
		case (ad.size)
			SZ_BYTE:  lane_mask = 8'h01;
			SZ_WYDE:  lane_mask = 8'h03;
			SZ_TETRA: lane_mask = 8'h0f;
			default:  lane_mask = 8'hff;
		endcase
	end

	// Any low address bit below the width makes the access misaligned
	assign misaligned = |(lane & (width[2:0] - 3'd1)) || (width[3] && lane != 3'd0);

	// An aligned run never crosses the top lane, so the shift cannot overflow
	assign byte_en_next = misaligned ? '0 : byte_en_t'(lane_mask << lane);

	// ==========================================================================
	// Output register
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= ad.valid;
	end

	always_ff @(posedge clk)
	begin
		out_tag        <= ad.tag;
		out_store      <= ad.is_store;
		out_sign_ext   <= ad.sign_ext;
		out_size       <= ad.size;
		out_addr       <= ad.addr;
		out_byte_en    <= byte_en_next;
		out_misaligned <= misaligned;
	end

	// An aligned access enables exactly as many lanes as it has bytes
	a_enable_count: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_misaligned) |->
			($countones(out_byte_en) == int'(size_bytes(out_size)))
	);

endmodule

//--- hdl/lsu_addr_top.sv
// ==========================================================================
// Top level of the load/store address path
// Joins decode, address generation and alignment into a three-stage
// pipeline with plain ports on both ends
// ==========================================================================

`timescale 1ns/1ps

module lsu_addr_top import lsu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	// Incoming memory instruction
	input  logic        in_valid,
	input  tag_t        in_tag,
	input  opcode_e     opcode,
	input  scale_t      scale,
	input  aregno_t     ra,
	input  aregno_t     rb,
	input  value_t      a,
	input  value_t      b,
	input  value_t      imm,
	input  pc_address_t pc,
	// Aligned access, three cycles after the instruction
	output logic        out_valid,
	output tag_t        out_tag,
	output logic        out_store,
	output logic        out_sign_ext,
	output mem_size_e   out_size,
	output value_t      out_addr,
	output byte_en_t    out_byte_en,
	output logic        out_misaligned
);

	// Stage links
	mem_op_if   op_link ();
	mem_addr_if addr_link ();

	// Decode and program counter substitution
	lsu_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_tag   (in_tag),
		.opcode   (opcode),
		.scale    (scale),
		.ra       (ra),
		.rb       (rb),
		.a        (a),
		.b        (b),
		.imm      (imm),
		.pc       (pc),
		.op       (op_link.src)
	);

	// Effective address
	lsu_agen u_agen (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (op_link.dst),
		.ad    (addr_link.src)
	);

	// Byte enables and misalignment
	lsu_align u_align (
		.clk            (clk),
		.rst_n          (rst_n),
		.ad             (addr_link.dst),
		.out_valid      (out_valid),
		.out_tag        (out_tag),
		.out_store      (out_store),
		.out_sign_ext   (out_sign_ext),
		.out_size       (out_size),
		.out_addr       (out_addr),
		.out_byte_en    (out_byte_en),
		.out_misaligned (out_misaligned)
	);

endmodule

//--- testbench/tb_lsu_addr.sv
// ==========================================================================
// Directed testbench for the load/store address path
// Reference model built from the address, scaling and alignment rules
// Fibonacci LFSR for operand values and a watchdog on the run time
// ==========================================================================

`timescale 1ns/1ps

module tb_lsu_addr import lsu_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	// Operations issued over all tests, sets the watchdog limit
	localparam int NUM_OPS = 73;

	typedef struct packed {
		opcode_e opc;
		tag_t    tag;
		scale_t  scale;
		aregno_t ra;
		aregno_t rb;
		value_t  a;
		value_t  b;
		value_t  imm;
		value_t  pc;
	} op_t;

	logic clk, rst_n, in_valid;
	tag_t in_tag;
	opcode_e opcode;
	scale_t scale;
	aregno_t ra, rb;
	value_t a, b, imm;
	pc_address_t pc;
	logic out_valid, out_store, out_sign_ext, out_misaligned;
	tag_t out_tag;
	mem_size_e out_size;
	value_t out_addr;
	byte_en_t out_byte_en;

	logic [31:0] lfsr = 32'hcb7d_a70a;
	op_t batch[$];
	tag_t next_tag = '0;
	int checks = 0;
	int errors = 0;

	lsu_addr_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Taps 32, 22, 2 and 1, one step per bit taken
	function automatic value_t rand_bits(input int n);
		value_t r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	// Any register number except the one that reads as the program counter
	function automatic aregno_t pick_reg();
		aregno_t r;
		r = aregno_t'(rand_bits(7));
		if (r == PC_REGNO)
			r = r + 7'd1;
		return r;
	endfunction

	task automatic check_field(input string name, input value_t got, input value_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Queue one operation with random operands and a fresh tag
	task automatic add_op(input opcode_e opc, input scale_t sc, input aregno_t ra_n,
		input aregno_t rb_n);
		op_t o;
		o.opc = opc;
		o.tag = next_tag;
		o.scale = sc;
		o.ra = ra_n;
		o.rb = rb_n;
		o.a = rand_bits(64);
		o.b = rand_bits(64);
		o.imm = rand_bits(64);
		o.pc = rand_bits(64);
		next_tag = next_tag + 4'd1;
		batch.push_back(o);
	endtask

	task automatic drive_op(input op_t o);
		in_valid = 1'b1;
		in_tag = o.tag;
		opcode = o.opc;
		scale = o.scale;
		ra = o.ra;
		rb = o.rb;
		a = o.a;
		b = o.b;
		imm = o.imm;
		pc = o.pc;
	endtask

	// ==========================================================================
	// Reference model, applied to the outputs three edges after issue
	// ==========================================================================

	task automatic check_op(input op_t o);
		logic mem, st, sx;
		mem_size_e sz;
		int form, width;
		value_t base, index, addr;
		logic mis;
		byte_en_t be;
		mem = 1'b1;
		st = 1'b0;
		sx = 1'b0;
		sz = SZ_OCTA;
		form = 0;
		case (o.opc)
			OP_LDB:  begin sz = SZ_BYTE; sx = 1'b1; end
			OP_LDBU: sz = SZ_BYTE;
			OP_LDW:  begin sz = SZ_WYDE; sx = 1'b1; end
			OP_LDWU: sz = SZ_WYDE;
			OP_LDT:  begin sz = SZ_TETRA; sx = 1'b1; end
			OP_LDTU: sz = SZ_TETRA;
			OP_LDO:  sz = SZ_OCTA;
			OP_STB:  begin sz = SZ_BYTE; st = 1'b1; end
			OP_STW:  begin sz = SZ_WYDE; st = 1'b1; end
			OP_STT:  begin sz = SZ_TETRA; st = 1'b1; end
			OP_STO:  st = 1'b1;
			OP_LDX:  form = 1;
			OP_STX:  begin form = 1; st = 1'b1; end
			OP_AMO:  form = 2;
			default: mem = 1'b0;
		endcase
		if (!mem)
		begin
			// A dropped opcode leaves an empty output slot
			check_field("out_valid", out_valid, 64'd0);
			return;
		end
		base = (o.ra == PC_REGNO) ? o.pc : o.a;
		index = (form != 2 && o.rb == PC_REGNO) ? o.pc : o.b;
		if (form == 1)
			addr = base + index * (64'd1 << o.scale) + o.imm;
		else if (form == 2)
			addr = base + index;
		else
			addr = base + o.imm;
		width = (sz == SZ_BYTE) ? 1 : (sz == SZ_WYDE) ? 2 : (sz == SZ_TETRA) ? 4 : 8;
		mis = (addr % width) != 0;
		be = '0;
		if (!mis)
			for (int k = 0; k < width; k++)
				be[addr[2:0] + k] = 1'b1;
		check_field("out_valid", out_valid, 64'd1);
		check_field("out_tag", out_tag, o.tag);
		check_field("out_store", out_store, st);
		check_field("out_sign_ext", out_sign_ext, sx);
		check_field("out_size", out_size, sz);
		check_field("out_addr", out_addr, addr);
		check_field("out_byte_en", out_byte_en, be);
		check_field("out_misaligned", out_misaligned, mis);
	endtask

	// Issues the queued operations back to back and checks each one
	// three rising edges after it was driven
	task automatic run_batch(input string name);
		int n;
		int start_errors;
		n = batch.size();
		start_errors = errors;
		for (int c = 0; c < n + 3; c++)
		begin
			@(negedge clk);
			if (c >= 3)
				check_op(batch[c - 3]);
			if (c < n)
				drive_op(batch[c]);
			else
				in_valid = 1'b0;
		end
		batch.delete();
		$display("%s: %0d operations, %0d errors", name, n, errors - start_errors);
	endtask

	// ==========================================================================
	// Directed tests
	// ==========================================================================

	task automatic test_displacement();
		opcode_e ops[11];
		ops = '{OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO,
			OP_STB, OP_STW, OP_STT, OP_STO};
		foreach (ops[i])
			add_op(ops[i], scale_t'(rand_bits(3)), pick_reg(), pick_reg());
		run_batch("displacement");
	endtask

	task automatic test_indexed();
		for (int s = 0; s < 8; s++)
		begin
			add_op(OP_LDX, scale_t'(s), pick_reg(), pick_reg());
			add_op(OP_STX, scale_t'(s), pick_reg(), pick_reg());
		end
		run_batch("indexed");
	endtask

	task automatic test_pc_operand();
		add_op(OP_LDO, 3'd2, PC_REGNO, pick_reg());
		add_op(OP_LDX, 3'd3, pick_reg(), PC_REGNO);
		add_op(OP_STX, 3'd7, PC_REGNO, PC_REGNO);
		// Atomics keep b as the index even when rb names the program counter
		add_op(OP_AMO, 3'd1, pick_reg(), PC_REGNO);
		run_batch("pc_operand");
	endtask

	task automatic test_atomic();
		for (int i = 0; i < 4; i++)
			add_op(OP_AMO, scale_t'(rand_bits(3)), pick_reg(), pick_reg());
		run_batch("atomic");
	endtask

	task automatic test_alignment();
		opcode_e ops[4];
		ops = '{OP_LDBU, OP_STW, OP_LDT, OP_STO};
		foreach (ops[i])
			for (int k = 0; k < 8; k++)
				add_op(ops[i], 3'd0, pick_reg(), pick_reg());
		run_batch("alignment");
	endtask

	task automatic test_throughput();
		add_op(OP_LDO, 3'd0, pick_reg(), pick_reg());
		add_op(OP_NOP, 3'd0, pick_reg(), pick_reg());
		add_op(OP_STB, 3'd0, pick_reg(), pick_reg());
		add_op(OP_LDWU, 3'd0, pick_reg(), pick_reg());
		add_op(OP_NOP, 3'd0, pick_reg(), pick_reg());
		add_op(OP_STX, 3'd4, pick_reg(), pick_reg());
		run_batch("throughput");
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_tag = '0;
		opcode = OP_NOP;
		scale = '0;
		ra = '0;
		rb = '0;
		a = '0;
		b = '0;
		imm = '0;
		pc = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_field("out_valid", out_valid, 64'd0);
		test_displacement();
		test_indexed();
		test_pc_operand();
		test_atomic();
		test_alignment();
		test_throughput();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Ten cycles per operation is far above the pipeline latency
	initial
	begin
		#(NUM_OPS * 10 * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

//--- src.f
hdl/lsu_pkg.sv
hdl/mem_op_if.sv
hdl/mem_addr_if.sv
hdl/lsu_decode.sv
hdl/lsu_agen.sv
hdl/lsu_align.sv
hdl/lsu_addr_top.sv
testbench/tb_lsu_addr.sv

//--- Bender.yml
package:
  name: lsu_addr

sources:
  - hdl/lsu_pkg.sv
  - hdl/mem_op_if.sv
  - hdl/mem_addr_if.sv
  - hdl/lsu_decode.sv
  - hdl/lsu_agen.sv
  - hdl/lsu_align.sv
  - hdl/lsu_addr_top.sv
  - target: test
    files:
      - testbench/tb_lsu_addr.sv
